/* flist.f */
+incdir+.
mips_isa_pkg.sv
mips_pipe_pkg.sv
fetch_unit.sv
reg_file.sv
decode_unit.sv
execute_unit.sv
mem_wb_unit.sv
mips_core.sv
tb_mips_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the mips_core testbench with Verilator, run it, then check the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ns --top-module tb_mips_core \
    -f flist.f -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }

cat sim.log
grep -q "Done: errors found" sim.log && { echo "Simulation reported errors"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0

/* tb_programs.svh */
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// MIPS32 field values of the instruction subset
localparam logic [5:0] OP_SPECIAL = 6'h00;
localparam logic [5:0] OP_J       = 6'h02;
localparam logic [5:0] OP_BEQ     = 6'h04;
localparam logic [5:0] OP_ORI     = 6'h0d;
localparam logic [5:0] OP_LUI     = 6'h0f;
localparam logic [5:0] OP_LW      = 6'h23;
localparam logic [5:0] OP_SW      = 6'h2b;
localparam logic [5:0] FN_ADDU    = 6'h21;
localparam logic [5:0] FN_SUBU    = 6'h23;
localparam logic [5:0] FN_AND     = 6'h24;
localparam logic [5:0] FN_OR      = 6'h25;
localparam logic [5:0] FN_SLT     = 6'h2a;

//////////////////////////////////////////////////
// Instruction encoders
//////////////////////////////////////////////////
function automatic logic [31:0] enc_r(input logic [5:0] funct, input int rd, input int rs,
                                      input int rt);
    return {OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], 5'd0, funct};
endfunction

function automatic logic [31:0] enc_i(input logic [5:0] op, input int rs, input int rt,
                                      input logic [15:0] imm);
    return {op, rs[4:0], rt[4:0], imm};
endfunction

// Jump target given as a byte address
function automatic logic [31:0] enc_j(input logic [5:0] op, input logic [31:0] target);
    return {op, target[27:2]};
endfunction

task automatic clear_imem();
    int i;
    for (i = 0; i < IMEM_WORDS; i++) begin
        imem[i] = 32'h0;
    end
endtask

//////////////////////////////////////////////////
// Program images
//////////////////////////////////////////////////
task automatic load_reset_prog();
    clear_imem();
    imem[0] = enc_i(OP_ORI, 0, 1, 16'h0001);
endtask

// Each instruction reads the result just before it
task automatic load_alu_prog(input logic [31:0] a, input logic [31:0] b);
    clear_imem();
    imem[0] = enc_i(OP_LUI, 0, 1, a[31:16]);
    imem[1] = enc_i(OP_ORI, 1, 1, a[15:0]);
    imem[2] = enc_i(OP_ORI, 1, 2, b[15:0]);
    imem[3] = enc_i(OP_LUI, 0, 3, b[31:16]);
    imem[4] = enc_r(FN_ADDU, 4, 3, 2);
    imem[5] = enc_r(FN_SUBU, 5, 4, 1);
    imem[6] = enc_r(FN_AND, 6, 5, 2);
    imem[7] = enc_r(FN_OR, 7, 6, 4);
    imem[8] = enc_r(FN_SLT, 8, 7, 5);
    imem[9] = enc_r(FN_SLT, 9, 1, 8);
endtask

task automatic load_mem_prog(input logic [31:0] v);
    clear_imem();
    imem[0] = enc_i(OP_ORI, 0, 1, 16'h0040);
    imem[1] = enc_i(OP_LUI, 0, 2, v[31:16]);
    imem[2] = enc_i(OP_ORI, 2, 2, v[15:0]);
    imem[3] = enc_i(OP_SW, 1, 2, 16'h0008);
    imem[4] = enc_i(OP_LW, 1, 3, 16'h0008);
    // Uses the loaded register right away
    imem[5] = enc_r(FN_ADDU, 4, 3, 2);
endtask

task automatic load_branch_prog();
    clear_imem();
    imem[0]  = enc_i(OP_ORI, 0, 1, 16'd5);
    imem[1]  = enc_i(OP_ORI, 0, 2, 16'd5);
    imem[2]  = enc_i(OP_BEQ, 1, 2, 16'd3);     // taken, to word 6
    imem[3]  = enc_i(OP_ORI, 0, 3, 16'd1);
    imem[4]  = enc_i(OP_ORI, 0, 4, 16'd2);
    imem[5]  = enc_i(OP_ORI, 0, 4, 16'd3);
    imem[6]  = enc_i(OP_BEQ, 1, 3, 16'd2);     // not taken
    imem[7]  = enc_i(OP_ORI, 0, 5, 16'd4);
    imem[8]  = enc_i(OP_ORI, 0, 6, 16'd6);
    imem[9]  = enc_j(OP_J, RESET_PC + 32'h30);
    imem[10] = enc_i(OP_ORI, 0, 7, 16'd7);
    imem[11] = enc_i(OP_ORI, 0, 8, 16'd8);
    imem[12] = enc_i(OP_ORI, 0, 9, 16'd9);
endtask

task automatic load_zero_prog();
    clear_imem();
    imem[0] = enc_i(OP_ORI, 0, 0, 16'h1234);
    imem[1] = enc_r(FN_ADDU, 1, 0, 0);
    imem[2] = enc_i(OP_ORI, 0, 2, 16'h0055);
    imem[3] = enc_r(FN_ADDU, 0, 2, 2);
    imem[4] = enc_r(FN_OR, 3, 0, 2);
endtask

`endif

/* tb_mips_core.sv */
`timescale 1ns/1ns

module tb_mips_core;

    localparam logic [31:0] RESET_PC     = 32'h0000_3000;
    localparam int          IMEM_WORDS   = 64;
    localparam int          WAIT_LIMIT   = 200;
    localparam int          DRAIN_CYCLES = 8;

    typedef struct packed {
        logic [4:0]  dst;
        logic [31:0] data;
        logic [31:0] pc;
    } trace_t;

    logic        clk;
    logic        rst_n;
    logic [31:0] inst_addr;
    logic [31:0] inst_rdata;
    logic [31:0] data_addr;
    logic [31:0] data_wdata;
    logic [3:0]  data_byteen;
    logic [31:0] data_rdata;
    logic        wb_we;
    logic [4:0]  wb_addr;
    logic [31:0] wb_wdata;
    logic [31:0] wb_pc;

    logic [31:0] imem [IMEM_WORDS];
    logic [31:0] dmem [64];
    logic [3:0]  store_byteen;
    logic [31:0] imem_idx;
    logic [31:0] lcg_state;
    trace_t      trace_q [$];
    trace_t      exp_q [$];
    int          errors;
    int          tests_run;
    int          tests_failed;

    `include "tb_programs.svh"

    mips_core #(.RESET_PC(RESET_PC)) uut (
        .clk(clk), .rst_n(rst_n), .inst_addr(inst_addr), .inst_rdata(inst_rdata),
        .data_addr(data_addr), .data_wdata(data_wdata), .data_byteen(data_byteen),
        .data_rdata(data_rdata), .wb_we(wb_we), .wb_addr(wb_addr), .wb_wdata(wb_wdata),
        .wb_pc(wb_pc)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Memory models and trace monitor
    //////////////////////////////////////////////////
    // Words outside the image read as the all-zero no-op
    assign imem_idx   = (inst_addr - RESET_PC) >> 2;
    assign inst_rdata = (imem_idx[31:6] == '0) ? imem[imem_idx[5:0]] : 32'h0;
    assign data_rdata = dmem[data_addr[7:2]];

    always @(posedge clk) begin : dmem_write
        int k;
        if (!rst_n) begin
            for (k = 0; k < 64; k++) begin
                dmem[k] <= 32'h0;
            end
            store_byteen <= 4'h0;
        end else if (data_byteen != 4'h0) begin
            dmem[data_addr[7:2]] <= data_wdata;
            // Byte enables seen on the last store
            store_byteen <= data_byteen;
        end
    end

    always @(negedge clk) begin
        if (!rst_n) begin
            trace_q.delete();
        end else if (wb_we) begin
            trace_q.push_back({wb_addr, wb_wdata, wb_pc});
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("[FAIL] %0t ns: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
        errors++;
    endtask

    task automatic expect_write(input int dst, input logic [31:0] data, input int word);
        logic [31:0] offs;
        offs = word;
        exp_q.push_back({dst[4:0], data, RESET_PC + (offs << 2)});
    endtask

    // Outputs that must stay quiet in and right after reset
    task automatic check_idle();
        if (wb_we !== 1'b0) begin
            report_mismatch("wb_we", {31'd0, wb_we}, 32'd0);
        end
        if (data_byteen !== 4'h0) begin
            report_mismatch("data_byteen", {28'd0, data_byteen}, 32'd0);
        end
        if (inst_addr !== RESET_PC) begin
            report_mismatch("inst_addr", inst_addr, RESET_PC);
        end
    endtask

    task automatic restart_core();
        int i;
        exp_q.delete();
        @(posedge clk);
        rst_n <= 1'b0;
        for (i = 0; i < 16; i++) begin
            @(negedge clk);
            check_idle();
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_idle();
    endtask

    task automatic compare_trace(input string test);
        int cycles;
        int i;
        cycles = 0;
        while (trace_q.size() < exp_q.size() && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (trace_q.size() < exp_q.size()) begin
            $display("Timeout in %s: only %0d of %0d register writes after %0d cycles",
                     test, trace_q.size(), exp_q.size(), cycles);
            errors++;
        end else begin
            // Stray writes from skipped instructions would land here
            repeat (DRAIN_CYCLES) @(negedge clk);
            @(posedge clk);
            if (trace_q.size() != exp_q.size()) begin
                $display("Error in %s: %0d register writes seen, %0d expected",
                         test, trace_q.size(), exp_q.size());
                errors++;
            end
            for (i = 0; i < exp_q.size(); i++) begin
                if (trace_q[i].dst !== exp_q[i].dst) begin
                    report_mismatch($sformatf("wb_addr[%0d]", i),
                                    {27'd0, trace_q[i].dst}, {27'd0, exp_q[i].dst});
                end
                if (trace_q[i].data !== exp_q[i].data) begin
                    report_mismatch($sformatf("wb_wdata[%0d]", i),
                                    trace_q[i].data, exp_q[i].data);
                end
                if (trace_q[i].pc !== exp_q[i].pc) begin
                    report_mismatch($sformatf("wb_pc[%0d]", i), trace_q[i].pc, exp_q[i].pc);
                end
            end
        end
    endtask

    task automatic end_test(input string name, input int start_errors);
        tests_run++;
        if (errors == start_errors) begin
            $display("Test %s: passed", name);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, errors - start_errors);
        end
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////
    task automatic test_reset();
        int start_errors;
        start_errors = errors;
        load_reset_prog();
        restart_core();
        expect_write(1, 32'h1, 0);
        compare_trace("reset");
        end_test("reset", start_errors);
    endtask

    task automatic test_alu_chain();
        int          start_errors;
        int          i;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res [10];
        start_errors = errors;
        a = lcg_next();
        b = lcg_next();
        load_alu_prog(a, b);
        restart_core();
        res[0] = {a[31:16], 16'h0};
        res[1] = res[0] | {16'h0, a[15:0]};
        res[2] = res[1] | {16'h0, b[15:0]};
        res[3] = {b[31:16], 16'h0};
        res[4] = res[3] + res[2];
        res[5] = res[4] - res[1];
        res[6] = res[5] & res[2];
        res[7] = res[6] | res[4];
        res[8] = ($signed(res[7]) < $signed(res[5])) ? 32'd1 : 32'd0;
        res[9] = ($signed(res[1]) < $signed(res[8])) ? 32'd1 : 32'd0;
        expect_write(1, res[0], 0);
        expect_write(1, res[1], 1);
        // Word n writes register n from word 2 on
        for (i = 2; i < 10; i++) begin
            expect_write(i, res[i], i);
        end
        compare_trace("alu_chain");
        end_test("alu_chain", start_errors);
    endtask

    task automatic test_store_load();
        int          start_errors;
        logic [31:0] v;
        start_errors = errors;
        v = lcg_next();
        load_mem_prog(v);
        restart_core();
        expect_write(1, 32'h40, 0);
        expect_write(2, {v[31:16], 16'h0}, 1);
        expect_write(2, v, 2);
        expect_write(3, v, 4);
        expect_write(4, v + v, 5);
        compare_trace("store_load");
        // Base 0x40 plus offset 8
        if (dmem[18] !== v) begin
            report_mismatch("dmem[0x48]", dmem[18], v);
        end
        // A word store enables all four bytes
        if (store_byteen !== 4'hf) begin
            report_mismatch("data_byteen", {28'd0, store_byteen}, 32'hf);
        end
        end_test("store_load", start_errors);
    endtask

    task automatic test_branches();
        int start_errors;
        start_errors = errors;
        load_branch_prog();
        restart_core();
        expect_write(1, 32'd5, 0);
        expect_write(2, 32'd5, 1);
        expect_write(3, 32'd1, 3);
        expect_write(5, 32'd4, 7);
        expect_write(6, 32'd6, 8);
        expect_write(7, 32'd7, 10);
        expect_write(9, 32'd9, 12);
        compare_trace("branches");
        end_test("branches", start_errors);
    endtask

    task automatic test_reg_zero();
        int start_errors;
        start_errors = errors;
        load_zero_prog();
        restart_core();
        expect_write(0, 32'h1234, 0);
        expect_write(1, 32'h0, 1);
        expect_write(2, 32'h55, 2);
        expect_write(0, 32'haa, 3);
        expect_write(3, 32'h55, 4);
        compare_trace("reg_zero");
        end_test("reg_zero", start_errors);
    endtask

    initial begin
        rst_n        = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        lcg_state    = 32'd16;
        test_reset();
        test_alu_chain();
        test_alu_chain();
        test_store_load();
        test_branches();
        test_reg_zero();
        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* mips_core.sv */
`timescale 1ns/1ns

module mips_core #(
    parameter logic [31:0] RESET_PC = 32'h0000_3000
) (
    input  logic        clk,
    input  logic        rst_n,
    output logic [31:0] inst_addr,
    input  logic [31:0] inst_rdata,
    output logic [31:0] data_addr,
    output logic [31:0] data_wdata,
    output logic [3:0]  data_byteen,
    input  logic [31:0] data_rdata,
    output logic        wb_we,
    output logic [4:0]  wb_addr,
    output logic [31:0] wb_wdata,
    output logic [31:0] wb_pc
);

    logic                      stall;
    logic                      branch_taken;
    logic [31:0]               branch_target;
    logic [4:0]                rs_addr;
    logic [4:0]                rt_addr;
    logic [31:0]               rs_data;
    logic [31:0]               rt_data;
    mips_pipe_pkg::fetch_rec_t fetch_rec;
    mips_pipe_pkg::issue_rec_t issue_rec;
    mips_pipe_pkg::mem_rec_t   mem_rec;
    mips_pipe_pkg::wb_rec_t    wb;

    //////////////////////////////////////////////////
    // Pipeline stages
    //////////////////////////////////////////////////
    fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (
        .clk(clk), .rst_n(rst_n), .stall(stall),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .inst_addr(inst_addr), .inst_rdata(inst_rdata), .fetch_rec(fetch_rec)
    );

    reg_file u_rf (
        .clk(clk), .rst_n(rst_n), .rs_addr(rs_addr), .rt_addr(rt_addr),
        .rs_data(rs_data), .rt_data(rt_data), .wb(wb)
    );

    // Decode sees its own issued record as the execute-stage occupant
    decode_unit u_decode (
        .clk(clk), .rst_n(rst_n), .fetch_rec(fetch_rec),
        .rs_addr(rs_addr), .rt_addr(rt_addr), .rs_data(rs_data), .rt_data(rt_data),
        .ex_rec(issue_rec), .mem_rec(mem_rec), .wb(wb),
        .stall(stall), .branch_taken(branch_taken), .branch_target(branch_target),
        .issue_rec(issue_rec)
    );

    execute_unit u_execute (
        .clk(clk), .rst_n(rst_n), .issue_rec(issue_rec), .wb(wb), .mem_rec(mem_rec)
    );

    mem_wb_unit u_mem_wb (
        .clk(clk), .rst_n(rst_n), .mem_rec(mem_rec),
        .data_addr(data_addr), .data_wdata(data_wdata), .data_byteen(data_byteen),
        .data_rdata(data_rdata), .wb(wb)
    );

    // Trace port
    assign wb_we    = wb.we;
    assign wb_addr  = wb.dst;
    assign wb_wdata = wb.data;
    assign wb_pc    = wb.pc;

endmodule

/* mem_wb_unit.sv */
`timescale 1ns/1ns

module mem_wb_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  mips_pipe_pkg::mem_rec_t mem_rec,
    output logic [31:0]             data_addr,
    output logic [31:0]             data_wdata,
    output logic [3:0]              data_byteen,
    input  logic [31:0]             data_rdata,
    output mips_pipe_pkg::wb_rec_t  wb
);

    logic        we_q;
    logic        is_load_q;
    logic [4:0]  dst_q;
    logic [31:0] alu_q;
    logic [31:0] load_q;
    logic [31:0] pc_q;

    //////////////////////////////////////////////////
    // Data port, word accesses only
    //////////////////////////////////////////////////
    assign data_addr   = mem_rec.alu_res;
    assign data_wdata  = mem_rec.store_data;
    assign data_byteen = mem_rec.is_store ? 4'hf : 4'h0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            we_q      <= 1'b0;
            is_load_q <= 1'b0;
            dst_q     <= '0;
        end else begin
            we_q      <= mem_rec.reg_we;
            is_load_q <= mem_rec.is_load;
            dst_q     <= mem_rec.dst;
        end
    end

    // Load data captured at the same edge as the result
    always_ff @(posedge clk) begin
        alu_q  <= mem_rec.alu_res;
        load_q <= data_rdata;
        pc_q   <= mem_rec.pc;
    end

    // Writeback select
    assign wb = '{
        we:   we_q,
        dst:  dst_q,
        data: is_load_q ? load_q : alu_q,
        pc:   pc_q
    };

endmodule

/* execute_unit.sv */
`timescale 1ns/1ns

module execute_unit (
    input  logic                      clk,
    input  logic                      rst_n,
    input  mips_pipe_pkg::issue_rec_t issue_rec,
    input  mips_pipe_pkg::wb_rec_t    wb,
    output mips_pipe_pkg::mem_rec_t   mem_rec
);

    logic [31:0] op_a;
    logic [31:0] rt_fwd;
    logic [31:0] op_b;
    logic [31:0] alu_res;

    // Bypass from the instruction one ahead, then from writeback
    assign op_a   = mips_pipe_pkg::forward_value(issue_rec.rs_addr, issue_rec.rs_val,
                                                 mem_rec, wb);
    assign rt_fwd = mips_pipe_pkg::forward_value(issue_rec.rt_addr, issue_rec.rt_val,
                                                 mem_rec, wb);
    assign op_b   = issue_rec.use_imm ? issue_rec.imm : rt_fwd;

    //////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////
    always_comb begin
        case (issue_rec.alu_op)
            mips_isa_pkg::alu_add: alu_res = op_a + op_b;
            mips_isa_pkg::alu_sub: alu_res = op_a - op_b;
            mips_isa_pkg::alu_and: alu_res = op_a & op_b;
            mips_isa_pkg::alu_or:  alu_res = op_a | op_b;
            // Signed compare
            mips_isa_pkg::alu_slt: alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
            mips_isa_pkg::alu_lui: alu_res = {op_b[15:0], 16'd0};
            default:               alu_res = '0;
        endcase
    end

    // Execute/memory register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_rec <= '0;
        end else begin
            mem_rec.alu_res    <= alu_res;
            mem_rec.store_data <= rt_fwd;
            mem_rec.dst        <= issue_rec.dst;
            mem_rec.reg_we     <= issue_rec.reg_we;
            mem_rec.is_load    <= issue_rec.is_load;
            mem_rec.is_store   <= issue_rec.is_store;
            mem_rec.pc         <= issue_rec.pc;
        end
    end

endmodule

/* decode_unit.sv */
`timescale 1ns/1ns

module decode_unit (
    input  logic                      clk,
    input  logic                      rst_n,
    input  mips_pipe_pkg::fetch_rec_t fetch_rec,
    output logic [4:0]                rs_addr,
    output logic [4:0]                rt_addr,
    input  logic [31:0]               rs_data,
    input  logic [31:0]               rt_data,
    input  mips_pipe_pkg::issue_rec_t ex_rec,
    input  mips_pipe_pkg::mem_rec_t   mem_rec,
    input  mips_pipe_pkg::wb_rec_t    wb,
    output logic                      stall,
    output logic                      branch_taken,
    output logic [31:0]               branch_target,
    output mips_pipe_pkg::issue_rec_t issue_rec
);

    logic [31:0]               instr;
    mips_isa_pkg::opcode_e     opcode;
    mips_isa_pkg::funct_e      funct;
    logic [4:0]                rd_addr;
    logic [15:0]               imm16;
    logic [31:0]               pc_slot;
    logic [31:0]               rs_fwd;
    logic [31:0]               rt_fwd;
    logic                      uses_rs;
    logic                      uses_rt;
    logic                      is_beq;
    logic                      is_jump;
    logic                      ex_hit;
    logic                      mem_hit;
    mips_pipe_pkg::issue_rec_t dec;

    // An empty slot decodes as the all-zero word, a no-op
    assign instr   = fetch_rec.valid ? fetch_rec.instr : '0;
    assign opcode  = mips_isa_pkg::opcode_e'(instr[31:26]);
    assign funct   = mips_isa_pkg::funct_e'(instr[5:0]);
    assign rs_addr = instr[25:21];
    assign rt_addr = instr[20:16];
    assign rd_addr = instr[15:11];
    assign imm16   = instr[15:0];
    assign pc_slot = fetch_rec.pc + 32'd4;

    assign rs_fwd = mips_pipe_pkg::forward_value(rs_addr, rs_data, mem_rec, wb);
    assign rt_fwd = mips_pipe_pkg::forward_value(rt_addr, rt_data, mem_rec, wb);

    //////////////////////////////////////////////////
    // Control decode
    //////////////////////////////////////////////////
    always_comb begin
        dec         = '0;
        uses_rs     = 1'b0;
        uses_rt     = 1'b0;
        is_beq      = 1'b0;
        is_jump     = 1'b0;
        dec.rs_addr = rs_addr;
        dec.rt_addr = rt_addr;
        dec.rs_val  = rs_fwd;
        dec.rt_val  = rt_fwd;
        dec.imm     = {{16{imm16[15]}}, imm16};
        dec.pc      = fetch_rec.pc;
        dec.pc8     = fetch_rec.pc + 32'd8;
        case (opcode)
            mips_isa_pkg::op_special: begin
                dec.dst    = rd_addr;
                dec.reg_we = 1'b1;
                uses_rs    = 1'b1;
                uses_rt    = 1'b1;
                case (funct)
                    mips_isa_pkg::fn_addu: dec.alu_op = mips_isa_pkg::alu_add;
                    mips_isa_pkg::fn_subu: dec.alu_op = mips_isa_pkg::alu_sub;
                    mips_isa_pkg::fn_and:  dec.alu_op = mips_isa_pkg::alu_and;
                    mips_isa_pkg::fn_or:   dec.alu_op = mips_isa_pkg::alu_or;
                    mips_isa_pkg::fn_slt:  dec.alu_op = mips_isa_pkg::alu_slt;
                    default: begin
                        dec.reg_we = 1'b0;
                        uses_rs    = 1'b0;
                        uses_rt    = 1'b0;
                    end
                endcase
            end
            mips_isa_pkg::op_ori: begin
                dec.alu_op  = mips_isa_pkg::alu_or;
                dec.imm     = {16'd0, imm16};
                dec.use_imm = 1'b1;
                dec.dst     = rt_addr;
                dec.reg_we  = 1'b1;
                uses_rs     = 1'b1;
            end
            mips_isa_pkg::op_lui: begin
                dec.alu_op  = mips_isa_pkg::alu_lui;
                dec.imm     = {16'd0, imm16};
                dec.use_imm = 1'b1;
                dec.dst     = rt_addr;
                dec.reg_we  = 1'b1;
            end
            mips_isa_pkg::op_lw: begin
                dec.use_imm = 1'b1;
                dec.dst     = rt_addr;
                dec.reg_we  = 1'b1;
                dec.is_load = 1'b1;
                uses_rs     = 1'b1;
            end
            mips_isa_pkg::op_sw: begin
                dec.use_imm  = 1'b1;
                dec.is_store = 1'b1;
                uses_rs      = 1'b1;
                uses_rt      = 1'b1;
            end
            mips_isa_pkg::op_beq: begin
                is_beq  = 1'b1;
                uses_rs = 1'b1;
                uses_rt = 1'b1;
            end
            mips_isa_pkg::op_j: is_jump = 1'b1;
            default: ;
        endcase
    end

    //////////////////////////////////////////////////
    // Hazards and branch resolution
    //////////////////////////////////////////////////
    assign ex_hit = (ex_rec.dst != 5'd0)
                    && ((uses_rs && ex_rec.dst == rs_addr) || (uses_rt && ex_rec.dst == rt_addr));
    assign mem_hit = (mem_rec.dst != 5'd0)
                     && ((uses_rs && mem_rec.dst == rs_addr) || (uses_rt && mem_rec.dst == rt_addr));

    // Load-use, plus beq needs its operands already here in decode
    assign stall = (ex_rec.is_load && ex_hit)
                   || (is_beq && ((ex_rec.reg_we && ex_hit) || (mem_rec.is_load && mem_hit)));

    assign branch_taken  = !stall && ((is_beq && rs_fwd == rt_fwd) || is_jump);
    assign branch_target = is_jump ? {pc_slot[31:28], instr[25:0], 2'b00}
                                   : pc_slot + {dec.imm[29:0], 2'b00};

    // Decode/execute register, bubble while stalled
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue_rec <= '0;
        end else if (stall) begin
            issue_rec <= '0;
        end else begin
            issue_rec <= dec;
        end
    end

endmodule

/* reg_file.sv */
`timescale 1ns/1ns

module reg_file (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [4:0]             rs_addr,
    input  logic [4:0]             rt_addr,
    output logic [31:0]            rs_data,
    output logic [31:0]            rt_data,
    input  mips_pipe_pkg::wb_rec_t wb
);

    logic [31:0] regs [32];

    // Same-cycle write is visible to the read, register zero reads as zero
    function automatic logic [31:0] read_reg(input logic [4:0] addr);
        logic [31:0] val;
        if (addr == 5'd0) begin
            val = '0;
        end else if (wb.we && wb.dst == addr) begin
            val = wb.data;
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.we && wb.dst != 5'd0) begin
            regs[wb.dst] <= wb.data;
        end
    end

    always_comb begin
        rs_data = read_reg(rs_addr);
        rt_data = read_reg(rt_addr);
    end

endmodule

/* fetch_unit.sv */
`timescale 1ns/1ns

module fetch_unit #(
    parameter logic [31:0] RESET_PC = 32'h0000_3000
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      stall,
    input  logic                      branch_taken,
    input  logic [31:0]               branch_target,
    output logic [31:0]               inst_addr,
    input  logic [31:0]               inst_rdata,
    output mips_pipe_pkg::fetch_rec_t fetch_rec
);

    logic [31:0] pc;
    logic [31:0] next_pc;

    // Branch resolved in decode redirects the fetch after the delay slot
    assign next_pc   = branch_taken ? branch_target : pc + 32'd4;
    assign inst_addr = pc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (!stall) begin
            pc <= next_pc;
        end
    end

    // Fetch/decode register, held on a stall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_rec <= '0;
        end else if (!stall) begin
            fetch_rec.valid <= 1'b1;
            fetch_rec.pc    <= pc;
            fetch_rec.instr <= inst_rdata;
        end
    end

endmodule

/* mips_pipe_pkg.sv */
package mips_pipe_pkg;

    // Fetch/decode register
    typedef struct packed {
        logic                              valid;
        logic [mips_isa_pkg::WORD_W-1:0]   pc;
        logic [mips_isa_pkg::WORD_W-1:0]   instr;
    } fetch_rec_t;

    // Decode/execute register
    typedef struct packed {
        mips_isa_pkg::alu_op_e                 alu_op;
        logic [mips_isa_pkg::WORD_W-1:0]       rs_val;
        logic [mips_isa_pkg::WORD_W-1:0]       rt_val;
        logic [mips_isa_pkg::REG_ADDR_W-1:0]   rs_addr;
        logic [mips_isa_pkg::REG_ADDR_W-1:0]   rt_addr;
        logic [mips_isa_pkg::WORD_W-1:0]       imm;
        logic [mips_isa_pkg::REG_ADDR_W-1:0]   dst;
        logic                                  reg_we;
        logic                                  is_load;
        logic                                  is_store;
        logic                                  use_imm;
        logic [mips_isa_pkg::WORD_W-1:0]       pc8;
        logic [mips_isa_pkg::WORD_W-1:0]       pc;
    } issue_rec_t;

    // Execute/memory register
    typedef struct packed {
        logic [mips_isa_pkg::WORD_W-1:0]       alu_res;
        logic [mips_isa_pkg::WORD_W-1:0]       store_data;
        logic [mips_isa_pkg::REG_ADDR_W-1:0]   dst;
        logic                                  reg_we;
        logic                                  is_load;
        logic                                  is_store;
        logic [mips_isa_pkg::WORD_W-1:0]       pc;
    } mem_rec_t;

    // Register write, as seen by the register file and the trace
    typedef struct packed {
        logic                                  we;
        logic [mips_isa_pkg::REG_ADDR_W-1:0]   dst;
        logic [mips_isa_pkg::WORD_W-1:0]       data;
        logic [mips_isa_pkg::WORD_W-1:0]       pc;
    } wb_rec_t;

    //////////////////////////////////////////////////
    // Operand bypass
    //////////////////////////////////////////////////
    // Memory-stage ALU result wins over writeback, then the register file.
    // A load in the memory stage only holds its address, so it is skipped
    function automatic logic [mips_isa_pkg::WORD_W-1:0] forward_value(
        input logic [mips_isa_pkg::REG_ADDR_W-1:0] addr,
        input logic [mips_isa_pkg::WORD_W-1:0]     rf_val,
        input mem_rec_t                            mem_rec,
        input wb_rec_t                             wb
    );
        logic [mips_isa_pkg::WORD_W-1:0] result;
        result = rf_val;
        if (addr != '0) begin
            if (mem_rec.reg_we && !mem_rec.is_load && mem_rec.dst == addr) begin
                result = mem_rec.alu_res;
            end else if (wb.we && wb.dst == addr) begin
                result = wb.data;
            end
        end
        return result;
    endfunction

endpackage

/* mips_isa_pkg.sv */
package mips_isa_pkg;

    // Field widths
    localparam int REG_ADDR_W = 5;
    localparam int WORD_W     = 32;

    //////////////////////////////////////////////////
    // Primary opcode, instr[31:26]
    //////////////////////////////////////////////////
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_j       = 6'h02,
        op_beq     = 6'h04,
        op_ori     = 6'h0d,
        op_lui     = 6'h0f,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_e;

    // Function field of special instructions, instr[5:0]
    typedef enum logic [5:0] {
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_slt  = 6'h2a
    } funct_e;

    //////////////////////////////////////////////////
    // ALU operations
    //////////////////////////////////////////////////
    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_slt = 3'd4,
        alu_lui = 3'd5
    } alu_op_e;

endpackage
